// File: Bender.yml
package:
  name: pipe_core

sources:
  - rvPkg.sv
  - regFile.sv
  - decoder.sv
  - aluUnit.sv
  - hazardUnit.sv
  - progMem.sv
  - dataMem.sv
  - pipeCore.sv
  - target: test
    files:
      - tbPipeCore.sv

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  rvPkg::aluOpT           i_Op,
    input  logic [rvPkg::XLEN-1:0] i_A,
    input  logic [rvPkg::XLEN-1:0] i_B,
    output logic [rvPkg::XLEN-1:0] o_Result,
    output logic                   o_Equal
);
    import rvPkg::*;

    logic wEqual;

    // branch resolution only looks at the equality flag
    assign wEqual  = (i_A == i_B);
    assign o_Equal = wEqual;

    always_comb begin
        case (i_Op)
            ALU_ADD:    o_Result = i_A + i_B;
            ALU_SUB:    o_Result = i_A - i_B;
            ALU_AND:    o_Result = i_A & i_B;
            ALU_OR:     o_Result = i_A | i_B;
            ALU_XOR:    o_Result = i_A ^ i_B;
            ALU_EQ_CMP: o_Result = {{(XLEN-1){1'b0}}, wEqual};
            default:    o_Result = '0;
        endcase
    end

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                      i_Clk,
    input  logic                      i_WrEn,
    input  logic [rvPkg::DATA_AW-1:0] i_Addr,
    input  logic [rvPkg::XLEN-1:0]    i_WrData,
    output logic [rvPkg::XLEN-1:0]    o_RdData
);
    import rvPkg::*;

    logic [XLEN-1:0] rMem [DATA_DEPTH];

    initial begin
        for (int i = 0; i < DATA_DEPTH; i++) begin
            rMem[i] = '0;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_WrEn) begin
            rMem[i_Addr] <= i_WrData;
        end
    end

    assign o_RdData = rMem[i_Addr];

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [rvPkg::XLEN-1:0] i_Instr,
    output rvPkg::decodedT         o_Dec
);
    import rvPkg::*;

    opcodeT          wOpcode;
    logic [2:0]      wFunct3;
    logic [6:0]      wFunct7;
    logic [XLEN-1:0] wImmI;
    logic [XLEN-1:0] wImmS;
    logic [XLEN-1:0] wImmB;
    logic            wKnown;

    assign wOpcode = opcodeT'(i_Instr[6:0]);
    assign wFunct3 = i_Instr[14:12];
    assign wFunct7 = i_Instr[31:25];

    assign wImmI = {{20{i_Instr[31]}}, i_Instr[31:20]};
    assign wImmS = {{20{i_Instr[31]}}, i_Instr[31:25], i_Instr[11:7]};
    assign wImmB = {{19{i_Instr[31]}}, i_Instr[31], i_Instr[7], i_Instr[30:25],
                    i_Instr[11:8], 1'b0};

    always_comb begin
        o_Dec         = '0;
        o_Dec.rs1Addr = i_Instr[19:15];
        o_Dec.rs2Addr = i_Instr[24:20];
        o_Dec.rd      = i_Instr[11:7];
        o_Dec.aluOp   = ALU_ADD;
        wKnown        = 1'b0;
        case (wOpcode)
            OP: begin
                wKnown         = 1'b1;
                o_Dec.rs1Valid = 1'b1;
                o_Dec.rs2Valid = 1'b1;
                o_Dec.regWr    = 1'b1;
                case ({wFunct7, wFunct3})
                    10'b0000000_000: o_Dec.aluOp = ALU_ADD;
                    10'b0100000_000: o_Dec.aluOp = ALU_SUB;
                    10'b0000000_111: o_Dec.aluOp = ALU_AND;
                    10'b0000000_110: o_Dec.aluOp = ALU_OR;
                    10'b0000000_100: o_Dec.aluOp = ALU_XOR;
                    default:         wKnown      = 1'b0;
                endcase
            end
            OP_IMM, LOAD: begin
                // ADDI and LW share the I-type layout
                wKnown         = (wOpcode == OP_IMM) ? (wFunct3 == 3'b000) : (wFunct3 == 3'b010);
                o_Dec.rs1Valid = 1'b1;
                o_Dec.regWr    = 1'b1;
                o_Dec.memRd    = (wOpcode == LOAD);
                o_Dec.immSel   = 1'b1;
                o_Dec.imm      = wImmI;
            end
            STORE: begin
                wKnown         = (wFunct3 == 3'b010);
                o_Dec.rs1Valid = 1'b1;
                o_Dec.rs2Valid = 1'b1;
                o_Dec.memWr    = 1'b1;
                o_Dec.immSel   = 1'b1;
                o_Dec.imm      = wImmS;
            end
            BRANCH: begin
                // funct3 000 is BEQ, 001 is BNE
                wKnown         = (wFunct3[2:1] == 2'b00);
                o_Dec.rs1Valid = 1'b1;
                o_Dec.rs2Valid = 1'b1;
                o_Dec.branch   = 1'b1;
                o_Dec.bne      = wFunct3[0];
                o_Dec.aluOp    = ALU_EQ_CMP;
                o_Dec.imm      = wImmB;
            end
            default: ;
        endcase
        if (!wKnown) begin
            o_Dec = '0;
        end else if (o_Dec.rd == '0) begin
            // writes to x0 are dropped here so they never stall or retire
            o_Dec.regWr = 1'b0;
        end
    end

endmodule

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  rvPkg::decodedT           i_Dec,
    input  logic [rvPkg::REG_AW-1:0] i_RdAddrE,
    input  logic [rvPkg::REG_AW-1:0] i_RdAddrM,
    input  logic [rvPkg::REG_AW-1:0] i_RdAddrW,
    input  logic                     i_RegWrE,
    input  logic                     i_RegWrM,
    input  logic                     i_RegWrW,
    input  logic                     i_BranchM,
    input  logic                     i_TakeM,
    output logic                     o_PcEn,
    output logic                     o_FetchEn,
    output logic                     o_ClrD,
    output logic                     o_ClrE,
    output logic                     o_ClrM
);
    import rvPkg::*;

    logic wHazE;
    logic wHazM;
    logic wHazW;
    logic wFlush;
    logic wStall;

    // true when the decoded instruction reads a register the older one still owes
    function automatic logic waitsOn(
        input decodedT           dec,
        input logic [REG_AW-1:0] rd,
        input logic              regWr
    );
        logic hit1;
        logic hit2;
        hit1 = dec.rs1Valid && (dec.rs1Addr != '0) && (dec.rs1Addr == rd);
        hit2 = dec.rs2Valid && (dec.rs2Addr != '0) && (dec.rs2Addr == rd);
        return regWr && (hit1 || hit2);
    endfunction

    assign wHazE = waitsOn(i_Dec, i_RdAddrE, i_RegWrE);
    assign wHazM = waitsOn(i_Dec, i_RdAddrM, i_RegWrM);
    // W match still costs a cycle although the register file bypasses it
    assign wHazW = waitsOn(i_Dec, i_RdAddrW, i_RegWrW);

    assign wFlush = i_BranchM & i_TakeM;
    assign wStall = wHazE | wHazM | wHazW;

    always_comb begin
        o_PcEn    = 1'b1;
        o_FetchEn = 1'b1;
        o_ClrD    = 1'b0;
        o_ClrE    = 1'b0;
        o_ClrM    = 1'b0;

        if (wFlush) begin
            // squash the three younger instructions behind the branch
            o_ClrD = 1'b1;
            o_ClrE = 1'b1;
            o_ClrM = 1'b1;
        end else if (wStall) begin
            // hold F and D, send a bubble into E
            o_PcEn    = 1'b0;
            o_FetchEn = 1'b0;
            o_ClrE    = 1'b1;
        end
    end

endmodule

// File: list.f
rvPkg.sv
regFile.sv
decoder.sv
aluUnit.sv
hazardUnit.sv
progMem.sv
dataMem.sv
pipeCore.sv
tbPipeCore.sv

// File: pipeCore.sv
`timescale 1ns/1ps

module pipeCore (
    input  logic                      i_Clk,
    input  logic                      i_rstN,
    input  logic                      i_LoadEn,
    input  logic [rvPkg::PROG_AW-1:0] i_LoadAddr,
    input  logic [rvPkg::XLEN-1:0]    i_LoadData,
    output rvPkg::retireT             o_Retire
);
    import rvPkg::*;

    logic [XLEN-1:0] rPc;
    logic [XLEN-1:0] wNextPc;
    logic [XLEN-1:0] wInstrF;
    logic [XLEN-1:0] rFdInstr;
    logic [XLEN-1:0] rFdPc;
    decodedT         wDecD;
    logic [XLEN-1:0] wRs1Data;
    logic [XLEN-1:0] wRs2Data;
    exStageT         rEx;
    memStageT        rMem;
    wbStageT         rWb;
    logic [XLEN-1:0] wAluB;
    logic [XLEN-1:0] wAluResult;
    logic [XLEN-1:0] wBrTarget;
    logic            wEqual;
    logic [XLEN-1:0] wMemRdData;
    logic            wTakeM;
    logic            wRedirect;
    logic            wPcEn;
    logic            wFetchEn;
    logic            wClrD;
    logic            wClrE;
    logic            wClrM;

    //////////////////////////////
    // fetch

    // the load port only works while the core is held in reset
    progMem progMem0 (
        .i_Clk      (i_Clk),
        .i_LoadEn   (i_LoadEn & ~i_rstN),
        .i_LoadAddr (i_LoadAddr),
        .i_LoadData (i_LoadData),
        .i_Addr     (rPc[XLEN-1:2]),
        .o_Instr    (wInstrF)
    );

    assign wNextPc = wRedirect ? rMem.brTarget : rPc + XLEN'(4);

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            rPc <= '0;
        end else if (wPcEn) begin
            rPc <= wNextPc;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN || wClrD) begin
            rFdInstr <= '0;
            rFdPc    <= '0;
        end else if (wFetchEn) begin
            rFdInstr <= wInstrF;
            rFdPc    <= rPc;
        end
    end

    //////////////////////////////
    // decode

    decoder decoder0 (
        .i_Instr (rFdInstr),
        .o_Dec   (wDecD)
    );

    regFile regFile0 (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_RdAddr1 (wDecD.rs1Addr),
        .i_RdAddr2 (wDecD.rs2Addr),
        .i_WrEn    (rWb.regWr),
        .i_WrAddr  (rWb.rd),
        .i_WrData  (rWb.data),
        .o_RdData1 (wRs1Data),
        .o_RdData2 (wRs2Data)
    );

    hazardUnit hazardUnit0 (
        .i_Dec     (wDecD),
        .i_RdAddrE (rEx.dec.rd),
        .i_RdAddrM (rMem.rd),
        .i_RdAddrW (rWb.rd),
        .i_RegWrE  (rEx.dec.regWr),
        .i_RegWrM  (rMem.regWr),
        .i_RegWrW  (rWb.regWr),
        .i_BranchM (rMem.branch),
        .i_TakeM   (wTakeM),
        .o_PcEn    (wPcEn),
        .o_FetchEn (wFetchEn),
        .o_ClrD    (wClrD),
        .o_ClrE    (wClrE),
        .o_ClrM    (wClrM)
    );

    always_ff @(posedge i_Clk) begin
        if (!i_rstN || wClrE) begin
            rEx <= '0;
        end else begin
            rEx.dec     <= wDecD;
            rEx.pc      <= rFdPc;
            rEx.rs1Data <= wRs1Data;
            rEx.rs2Data <= wRs2Data;
        end
    end

    //////////////////////////////
    // execute

    assign wAluB = rEx.dec.immSel ? rEx.dec.imm : rEx.rs2Data;

    aluUnit aluExe0 (
        .i_Op     (rEx.dec.aluOp),
        .i_A      (rEx.rs1Data),
        .i_B      (wAluB),
        .o_Result (wAluResult),
        .o_Equal  (wEqual)
    );

    // second copy only forms pc + imm for the branch target
    aluUnit aluBr0 (
        .i_Op     (ALU_ADD),
        .i_A      (rEx.pc),
        .i_B      (rEx.dec.imm),
        .o_Result (wBrTarget),
        .o_Equal  ()
    );

    always_ff @(posedge i_Clk) begin
        if (!i_rstN || wClrM) begin
            rMem <= '0;
        end else begin
            rMem.rd        <= rEx.dec.rd;
            rMem.regWr     <= rEx.dec.regWr;
            rMem.memRd     <= rEx.dec.memRd;
            rMem.memWr     <= rEx.dec.memWr;
            rMem.branch    <= rEx.dec.branch;
            rMem.bne       <= rEx.dec.bne;
            rMem.aluResult <= wAluResult;
            rMem.storeData <= rEx.rs2Data;
            rMem.brTarget  <= wBrTarget;
            rMem.brEqual   <= wEqual;
        end
    end

    //////////////////////////////
    // memory and writeback

    dataMem dataMem0 (
        .i_Clk    (i_Clk),
        .i_WrEn   (rMem.memWr),
        .i_Addr   (rMem.aluResult[DATA_AW+1:2]),
        .i_WrData (rMem.storeData),
        .o_RdData (wMemRdData)
    );

    assign wTakeM    = rMem.brEqual ^ rMem.bne;
    assign wRedirect = rMem.branch & wTakeM;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            rWb <= '0;
        end else begin
            rWb.regWr <= rMem.regWr;
            rWb.rd    <= rMem.rd;
            rWb.data  <= rMem.memRd ? wMemRdData : rMem.aluResult;
        end
    end

    assign o_Retire = '{valid: rWb.regWr, rd: rWb.rd, data: rWb.data};

endmodule

// File: progMem.sv
`timescale 1ns/1ps

module progMem (
    input  logic                      i_Clk,
    input  logic                      i_LoadEn,
    input  logic [rvPkg::PROG_AW-1:0] i_LoadAddr,
    input  logic [rvPkg::XLEN-1:0]    i_LoadData,
    input  logic [rvPkg::XLEN-3:0]    i_Addr,
    output logic [rvPkg::XLEN-1:0]    o_Instr
);
    import rvPkg::*;

    logic [XLEN-1:0] rMem [PROG_DEPTH];

    always_ff @(posedge i_Clk) begin
        if (i_LoadEn) begin
            rMem[i_LoadAddr] <= i_LoadData;
        end
    end

    // past the end of the array the core sees zero words
    assign o_Instr = (i_Addr < PROG_DEPTH) ? rMem[i_Addr[PROG_AW-1:0]] : '0;

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                     i_Clk,
    input  logic                     i_rstN,
    input  logic [rvPkg::REG_AW-1:0] i_RdAddr1,
    input  logic [rvPkg::REG_AW-1:0] i_RdAddr2,
    input  logic                     i_WrEn,
    input  logic [rvPkg::REG_AW-1:0] i_WrAddr,
    input  logic [rvPkg::XLEN-1:0]   i_WrData,
    output logic [rvPkg::XLEN-1:0]   o_RdData1,
    output logic [rvPkg::XLEN-1:0]   o_RdData2
);
    import rvPkg::*;

    logic [XLEN-1:0] rRegs [2**REG_AW];

    // x0 reads zero, a write in flight is passed straight to the reader
    function automatic logic [XLEN-1:0] readPort(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_WrEn && (addr == i_WrAddr)) begin
            return i_WrData;
        end
        return rRegs[addr];
    endfunction

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                rRegs[i] <= '0;
            end
        end else if (i_WrEn && (i_WrAddr != '0)) begin
            rRegs[i_WrAddr] <= i_WrData;
        end
    end

    always_comb begin
        o_RdData1 = readPort(i_RdAddr1);
        o_RdData2 = readPort(i_RdAddr2);
    end

endmodule

// File: rvPkg.sv
package rvPkg;

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int PROG_DEPTH = 64;
    localparam int DATA_DEPTH = 64;
    localparam int PROG_AW    = $clog2(PROG_DEPTH);
    localparam int DATA_AW    = $clog2(DATA_DEPTH);

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_EQ_CMP
    } aluOpT;

    typedef struct packed {
        logic [REG_AW-1:0] rs1Addr;
        logic              rs1Valid;
        logic [REG_AW-1:0] rs2Addr;
        logic              rs2Valid;
        logic [REG_AW-1:0] rd;
        logic              regWr;
        logic              memRd;
        logic              memWr;
        logic              branch;
        logic              bne;
        aluOpT             aluOp;
        logic              immSel;
        logic [XLEN-1:0]   imm;
    } decodedT;

    typedef struct packed {
        decodedT         dec;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Data;
        logic [XLEN-1:0] rs2Data;
    } exStageT;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              regWr;
        logic              memRd;
        logic              memWr;
        logic              branch;
        logic              bne;
        logic [XLEN-1:0]   aluResult;
        logic [XLEN-1:0]   storeData;
        logic [XLEN-1:0]   brTarget;
        logic              brEqual;
    } memStageT;

    typedef struct packed {
        logic              regWr;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wbStageT;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } retireT;

endpackage

// File: tbPipeCore.sv
`timescale 1ns/1ps

module tbPipeCore;
    import rvPkg::*;

    // summed program lengths of the five tests below
    localparam int TOTAL_INSTR     = 68;
    localparam int N_TESTS         = 5;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 8 + N_TESTS * 100;
    localparam int R_ADD = 0;
    localparam int R_SUB = 1;
    localparam int R_AND = 2;
    localparam int R_OR  = 3;
    localparam int R_XOR = 4;

    logic                i_Clk;
    logic                i_rstN;
    logic                i_LoadEn;
    logic [PROG_AW-1:0]  i_LoadAddr;
    logic [XLEN-1:0]     i_LoadData;
    retireT              o_Retire;

    logic [XLEN-1:0] prog [$];
    retireT          expQ [$];
    retireT          expRec;
    logic [XLEN-1:0] modelMem [DATA_DEPTH];
    logic [31:0]     rngState;
    string           curTest;
    int              valueErrs;
    int              missingErrs;
    int              otherErrs;
    int              rstCycles;
    int              postCnt;

    pipeCore dut0 (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_LoadEn   (i_LoadEn),
        .i_LoadAddr (i_LoadAddr),
        .i_LoadData (i_LoadData),
        .o_Retire   (o_Retire)
    );

    initial begin
        i_Clk = 1'b0;
        forever #5 i_Clk = ~i_Clk;
    end

    //////////////////////////////
    // instruction encoding

    function automatic logic [31:0] rOp(input int sel, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (sel == R_SUB) ? 7'b0100000 : 7'b0000000;
        case (sel)
            R_AND:   f3 = 3'b111;
            R_OR:    f3 = 3'b110;
            R_XOR:   f3 = 3'b100;
            default: f3 = 3'b000;
        endcase
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // funct3 000 gives BEQ, 001 gives BNE
    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////
    // sequential ISA model

    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (((pc >> 2) < prog.size()) && (steps < 200)) begin
            w      = prog[pc >> 2];
            a      = regs[w[19:15]];
            b      = regs[w[24:20]];
            immI   = {{20{w[31]}}, w[31:20]};
            immS   = {{20{w[31]}}, w[31:25], w[11:7]};
            immB   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            nextPc = pc + 4;
            wr     = 1'b0;
            res    = '0;
            case (opcodeT'(w[6:0]))
                OP: begin
                    wr = 1'b1;
                    case ({w[31:25], w[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        default:         wr  = 1'b0;
                    endcase
                end
                OP_IMM: begin
                    wr  = (w[14:12] == 3'b000);
                    res = a + immI;
                end
                LOAD: begin
                    addr = a + immI;
                    wr   = (w[14:12] == 3'b010);
                    res  = modelMem[addr[DATA_AW+1:2]];
                end
                STORE: begin
                    addr = a + immS;
                    if (w[14:12] == 3'b010) begin
                        modelMem[addr[DATA_AW+1:2]] = b;
                    end
                end
                BRANCH: begin
                    if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
                        nextPc = pc + immB;
                    end
                end
                default: ;
            endcase
            // x0 writes are dropped and never retire
            if (wr && (w[11:7] != 5'd0)) begin
                regs[w[11:7]] = res;
                expQ.push_back('{valid: 1'b1, rd: w[11:7], data: res});
            end
            pc = nextPc;
            steps++;
        end
    endtask

    //////////////////////////////
    // reset, load and run

    // a BEQ x0,x0,0 after the program parks the core in a self loop
    task automatic resetAndLoad();
        int n;
        int cycles;
        n      = prog.size() + 1;
        cycles = (n > 8) ? n : 8;
        @(negedge i_Clk);
        i_rstN = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            i_LoadEn   = (i < n);
            i_LoadAddr = PROG_AW'(i);
            i_LoadData = (i < prog.size()) ? prog[i] : branch(3'b000, 5'd0, 5'd0, 13'd0);
            @(negedge i_Clk);
        end
        i_LoadEn = 1'b0;
        i_rstN   = 1'b1;
    endtask

    task automatic runTest(input string name);
        int limit;
        int waited;
        curTest = name;
        expQ.delete();
        runModel();
        resetAndLoad();
        limit  = (prog.size() + 1) * 8 + 20;
        waited = 0;
        while ((expQ.size() != 0) && (waited < limit)) begin
            @(negedge i_Clk);
            waited++;
        end
        // extra cycles catch retires of instructions that should have been skipped
        repeat (8) @(negedge i_Clk);
        if (expQ.size() != 0) begin
            missingErrs += expQ.size();
            $display("%s: %0d expected retires never appeared", name, expQ.size());
        end
        expQ.delete();
    endtask

    task automatic buildRandom();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        prog.delete();
        for (int k = 0; k < 30; k++) begin
            rngState = xorshift32(rngState);
            rd  = 5'((rngState >> 12) % 5);
            rs1 = 5'((rngState >> 16) % 5);
            rs2 = 5'((rngState >> 20) % 5);
            case (rngState % 5)
                0, 1:    prog.push_back(rOp((rngState >> 8) % 5, rd, rs1, rs2));
                2:       prog.push_back(addi(rd, rs1, {{4{rngState[31]}}, rngState[31:24]}));
                3:       prog.push_back(lw(rd, 5'd0, 12'(((rngState >> 24) % 8) * 4)));
                default: prog.push_back(sw(rs2, 5'd0, 12'(((rngState >> 24) % 8) * 4)));
            endcase
        end
    endtask

    //////////////////////////////
    // retire checks

    always @(posedge i_Clk) begin
        if (!i_rstN) begin
            if (rstCycles > 0) begin
                assert (!o_Retire.valid) else begin
                    otherErrs++;
                    $display("%s: retire strobe seen while reset is held", curTest);
                end
            end
            rstCycles++;
            postCnt = 0;
        end else begin
            rstCycles = 0;
            if (postCnt < 4) begin
                assert (!o_Retire.valid) else begin
                    otherErrs++;
                    $display("%s: retire strobe too soon after reset", curTest);
                end
            end
            postCnt++;
            if (o_Retire.valid) begin
                if (expQ.size() == 0) begin
                    otherErrs++;
                    $display("%s: unexpected retire of x%0d = 0x%08h", curTest,
                             o_Retire.rd, o_Retire.data);
                end else begin
                    expRec = expQ.pop_front();
                    assert ((o_Retire.rd == expRec.rd) && (o_Retire.data == expRec.data)) else begin
                        valueErrs++;
                        $display("Error: %s expected x%0d=0x%08h actual x%0d=0x%08h", curTest,
                                 expRec.rd, expRec.data, o_Retire.rd, o_Retire.data);
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_Clk);
        $display("watchdog expired after %0d cycles during %s", WATCHDOG_CYCLES, curTest);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // tests

    initial begin
        i_rstN      = 1'b0;
        i_LoadEn    = 1'b0;
        i_LoadAddr  = '0;
        i_LoadData  = '0;
        rngState    = 32'h5059;
        curTest     = "init";
        valueErrs   = 0;
        missingErrs = 0;
        otherErrs   = 0;
        rstCycles   = 0;
        postCnt     = 0;
        for (int i = 0; i < DATA_DEPTH; i++) begin
            modelMem[i] = '0;
        end

        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, -12'sd3));
        prog.push_back(addi(5'd3, 5'd0, 12'd12));
        prog.push_back(addi(5'd4, 5'd0, 12'd10));
        prog.push_back(rOp(R_ADD, 5'd5, 5'd1, 5'd2));
        prog.push_back(rOp(R_SUB, 5'd6, 5'd3, 5'd4));
        prog.push_back(rOp(R_AND, 5'd7, 5'd1, 5'd3));
        prog.push_back(rOp(R_OR, 5'd8, 5'd2, 5'd4));
        prog.push_back(rOp(R_XOR, 5'd9, 5'd3, 5'd1));
        runTest("alu");

        // dependences at distance one, two and three, then x0 as a target
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd7));
        prog.push_back(addi(5'd2, 5'd1, 12'd3));
        prog.push_back(addi(5'd5, 5'd0, 12'd1));
        prog.push_back(addi(5'd3, 5'd2, 12'd4));
        prog.push_back(addi(5'd6, 5'd0, 12'd1));
        prog.push_back(addi(5'd7, 5'd0, 12'd1));
        prog.push_back(rOp(R_SUB, 5'd4, 5'd3, 5'd1));
        prog.push_back(addi(5'd0, 5'd1, 12'd9));
        prog.push_back(rOp(R_ADD, 5'd8, 5'd0, 5'd2));
        runTest("raw");

        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'h055));
        prog.push_back(sw(5'd1, 5'd0, 12'd8));
        prog.push_back(lw(5'd2, 5'd0, 12'd8));
        prog.push_back(addi(5'd3, 5'd2, 12'd1));
        prog.push_back(addi(5'd4, 5'd0, 12'd16));
        prog.push_back(sw(5'd3, 5'd4, 12'd0));
        prog.push_back(lw(5'd5, 5'd0, 12'd16));
        prog.push_back(rOp(R_ADD, 5'd6, 5'd5, 5'd2));
        runTest("mem");

        // taken BEQ and BNE skip two each, the last two branches fall through
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd3));
        prog.push_back(addi(5'd2, 5'd0, 12'd3));
        prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd12));
        prog.push_back(addi(5'd3, 5'd0, 12'd1));
        prog.push_back(addi(5'd4, 5'd0, 12'd1));
        prog.push_back(branch(3'b001, 5'd1, 5'd0, 13'd12));
        prog.push_back(addi(5'd5, 5'd0, 12'd1));
        prog.push_back(addi(5'd6, 5'd0, 12'd1));
        prog.push_back(branch(3'b000, 5'd1, 5'd0, 13'd8));
        prog.push_back(addi(5'd7, 5'd0, 12'd2));
        prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
        prog.push_back(addi(5'd8, 5'd0, 12'd4));
        runTest("branch");

        buildRandom();
        runTest("random");

        $display("errors: %0d value, %0d missing, %0d other", valueErrs, missingErrs, otherErrs);
        if ((valueErrs + missingErrs + otherErrs) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
